//--- files.f
+incdir+tests
logic/sd_line_pkg.sv
logic/sd_sample_pkg.sv
logic/sd_manchester_decoder.sv
logic/sd_integrator.sv
logic/sd_differentiator.sv
logic/sd_channel.sv
logic/sd_adc_top.sv
tests/sd_adc_tb.sv

//--- tests/sd_adc_model.svh
// Reference model for the ADC front end, included inside the testbench module
// Assumes a first-order CIC, so a window's result depends only on its count of ones
`ifndef SD_ADC_MODEL_SVH
`define SD_ADC_MODEL_SVH

// Modulator bits per decimation window
localparam int window_bits = 512;

// Next value of the stimulus generator
function automatic logic [31:0] lcg_next(logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

// High half carries the bit, low half its inverse
function automatic logic [1:0] manchester_encode(logic value);
    return {value, ~value};
endfunction

// Number of ones sent during one window
function automatic int window_ones(logic [window_bits-1:0] bits);
    int ones;
    ones = 0;
    for (int i = 0; i < window_bits; i++) begin
        if (bits[i]) begin
            ones++;
        end
    end
    return ones;
endfunction

// Output-stage rule: shift, clamp on overrange, remove the mid-scale offset
function automatic logic [sd_sample_pkg::default_output_size-1:0] expected_sample(int ones);
    int shifted;
    int full_scale;
    int value;
    shifted = ones / (2 ** sd_sample_pkg::default_output_shift);
    full_scale = 2 ** sd_sample_pkg::default_result_resolution;
    if (shifted >= full_scale) begin
        value = full_scale / 2 - 1;
    end else begin
        value = shifted - full_scale / 2;
    end
    // The low bits of a two's complement int are already the sign-extended sample
    return value[sd_sample_pkg::default_output_size-1:0];
endfunction

`endif

//--- tests/sd_adc_tb.sv
// Drives both channels with LCG bit streams and checks every sample against the model
// All line inputs change 1 ns after a rising clock edge, outputs are sampled on the falling edge
`timescale 1ns/1ps

module sd_adc_tb;

    `include "sd_adc_model.svh"

    localparam int output_size = sd_sample_pkg::default_output_size;
    localparam int total_windows = 11;
    localparam int timeout_cycles = total_windows * 4096 + 20000;

    typedef struct packed {
        logic [1:0][output_size-1:0] data;
        logic [1:0]                  error;
    } expect_t;

    logic                             clock;
    logic                             rst_n;
    sd_line_pkg::line_mode_e          line_mode;
    logic                             sd_clock_in;
    logic [1:0]                       sd_data_in;
    logic                             output_clock;
    logic                             sync;
    logic [1:0][output_size-1:0]      sample_data;
    logic [1:0]                       sample_valid;
    sd_sample_pkg::channel_id_t [1:0] sample_dest;
    logic [1:0]                       code_error;

    logic [31:0] lcg_state;
    expect_t     expect_q[$];
    int          pending_age;
    int          error_count;
    int          test_count;
    int          failed_tests;
    int          test_start_errors;
    int          cycle_count;

    sd_adc_top #(
        .PROCESSING_RESOLUTION (sd_sample_pkg::default_processing_resolution),
        .RESULT_RESOLUTION     (sd_sample_pkg::default_result_resolution),
        .OUTPUT_SIZE           (sd_sample_pkg::default_output_size),
        .OUTPUT_SHIFT          (sd_sample_pkg::default_output_shift)
    ) u_sd_adc_top (
        .clock        (clock),
        .rst_n        (rst_n),
        .line_mode    (line_mode),
        .sd_clock_in  (sd_clock_in),
        .sd_data_in   (sd_data_in),
        .output_clock (output_clock),
        .sync         (sync),
        .sample_data  (sample_data),
        .sample_valid (sample_valid),
        .sample_dest  (sample_dest),
        .code_error   (code_error)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    task automatic check_data(string name, logic [output_size-1:0] got,
                              logic [output_size-1:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name,
                     $signed(got), $signed(exp));
            error_count++;
        end
    endtask

    task automatic check_dest(string name, sd_sample_pkg::channel_id_t got,
                              sd_sample_pkg::channel_id_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_error(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
            error_count++;
        end
    endtask

    // Each sample_valid consumes the oldest outstanding sync request
    always @(negedge clock) begin : compare_samples
        expect_t entry;
        if (sample_valid !== 2'b00) begin
            pending_age = 0;
            if (sample_valid !== 2'b11) begin
                $display("Channels raised sample_valid in different cycles at %0t", $time);
                error_count++;
            end
            if (expect_q.size() == 0) begin
                $display("sample_valid was high at %0t without a sync request", $time);
                error_count++;
            end else begin
                entry = expect_q.pop_front();
                for (int ch = 0; ch < 2; ch++) begin
                    check_data($sformatf("sample_data[%0d]", ch), sample_data[ch],
                               entry.data[ch]);
                    check_dest($sformatf("sample_dest[%0d]", ch), sample_dest[ch],
                               sd_sample_pkg::channel_id_t'(ch));
                    check_error($sformatf("code_error[%0d]", ch), code_error[ch],
                                entry.error[ch]);
                end
            end
        end else if (expect_q.size() > 0) begin
            pending_age++;
            if (pending_age > 4) begin
                $display("No sample_valid came within 4 cycles of sync at %0t", $time);
                error_count++;
                expect_q.delete();
                pending_age = 0;
            end
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("Run stopped after %0d cycles without finishing the tests", cycle_count);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        sd_clock_in = 1'b0;
        sd_data_in = 2'b00;
        output_clock = 1'b0;
        sync = 1'b0;
        repeat (5) next_cycle();
        rst_n = 1'b1;
    endtask

    task automatic request_sample(expect_t entry);
        sync = 1'b1;
        expect_q.push_back(entry);
        next_cycle();
        sync = 1'b0;
        repeat (6) next_cycle();
    endtask

    // One modulator bit per channel over 8 cycles, sd_clock_in high for the first 4
    task automatic drive_bit(logic [1:0] bits, logic corrupt, int index, logic sync_now,
                             expect_t entry);
        logic [1:0] halves [2];
        for (int ch = 0; ch < 2; ch++) begin
            if (line_mode == sd_line_pkg::line_manchester) begin
                halves[ch] = manchester_encode(bits[ch]);
            end else begin
                halves[ch] = {bits[ch], bits[ch]};
            end
        end
        // Equal halves make an invalid Manchester symbol on channel 1
        if (corrupt) begin
            halves[1] = {bits[1], bits[1]};
        end
        for (int c = 0; c < 8; c++) begin
            if (c == 0) begin
                sd_clock_in = 1'b1;
                sd_data_in = {halves[1][1], halves[0][1]};
            end
            if (c == 4) begin
                sd_clock_in = 1'b0;
                sd_data_in = {halves[1][0], halves[0][0]};
                if (sync_now) begin
                    sync = 1'b1;
                    expect_q.push_back(entry);
                end
            end
            if (c == 5) begin
                sync = 1'b0;
            end
            // output_clock rises 2 cycles after the last bit's falling edge
            if (c == 6 && index == window_bits - 1) begin
                output_clock = 1'b1;
            end
            if (c == 6 && index == window_bits / 2 - 1) begin
                output_clock = 1'b0;
            end
            next_cycle();
        end
    endtask

    // Density is the chance of a one in 256ths
    task automatic run_windows(int n_windows, int density0, int density1, int bad_bit,
                               logic [1:0] err_expected);
        logic [window_bits-1:0] bits [2];
        int      density [2];
        expect_t current;
        expect_t previous;
        logic    have_previous;
        density[0] = density0;
        density[1] = density1;
        have_previous = 1'b0;
        for (int w = 0; w < n_windows; w++) begin
            for (int i = 0; i < window_bits; i++) begin
                for (int ch = 0; ch < 2; ch++) begin
                    lcg_state = lcg_next(lcg_state);
                    bits[ch][i] = (lcg_state[31:24] < density[ch]);
                end
            end
            for (int ch = 0; ch < 2; ch++) begin
                current.data[ch] = expected_sample(window_ones(bits[ch]));
            end
            current.error = err_expected;
            // The previous window's sample is requested early in this window
            for (int i = 0; i < window_bits; i++) begin
                drive_bit({bits[1][i], bits[0][i]}, (w == 0) && (i == bad_bit), i,
                          have_previous && (i == 0), previous);
            end
            previous = current;
            have_previous = 1'b1;
        end
        repeat (4) next_cycle();
        request_sample(previous);
    endtask

    task automatic finish_test(string name);
        test_count++;
        if (error_count != test_start_errors) begin
            failed_tests++;
        end
        $display("Test %0s finished with %0d errors", name, error_count - test_start_errors);
        test_start_errors = error_count;
    endtask

    initial begin
        expect_t idle_entry;
        rst_n = 1'b0;
        line_mode = sd_line_pkg::line_plain;
        sd_clock_in = 1'b0;
        sd_data_in = 2'b00;
        output_clock = 1'b0;
        sync = 1'b0;
        lcg_state = 32'hfc359bfd;
        pending_age = 0;
        error_count = 0;
        test_count = 0;
        failed_tests = 0;
        test_start_errors = 0;
        cycle_count = 0;

        apply_reset();
        repeat (20) next_cycle();
        idle_entry.data[0] = expected_sample(0);
        idle_entry.data[1] = expected_sample(0);
        idle_entry.error = 2'b00;
        request_sample(idle_entry);
        finish_test("reset");

        line_mode = sd_line_pkg::line_plain;
        apply_reset();
        run_windows(4, 128, 64, -1, 2'b00);
        finish_test("plain");

        line_mode = sd_line_pkg::line_manchester;
        apply_reset();
        run_windows(4, 128, 64, -1, 2'b00);
        finish_test("manchester");

        line_mode = sd_line_pkg::line_plain;
        apply_reset();
        run_windows(1, 256, 0, -1, 2'b00);
        finish_test("clamp");

        line_mode = sd_line_pkg::line_manchester;
        apply_reset();
        run_windows(2, 128, 128, 100, 2'b10);
        finish_test("code_error");

        $display("%0d tests run, %0d failed, %0d check errors", test_count, failed_tests,
                 error_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- logic/sd_adc_top.sv
// Two-channel front end, all line inputs assumed synchronous to clock
// Both channels share sd_clock_in, output_clock, line_mode and sync
`timescale 1ns/1ps

module sd_adc_top #(
    parameter int PROCESSING_RESOLUTION = sd_sample_pkg::default_processing_resolution,
    parameter int RESULT_RESOLUTION     = sd_sample_pkg::default_result_resolution,
    parameter int OUTPUT_SIZE           = sd_sample_pkg::default_output_size,
    parameter int OUTPUT_SHIFT          = sd_sample_pkg::default_output_shift
) (
    input  logic                             clock,
    input  logic                             rst_n,
    input  sd_line_pkg::line_mode_e          line_mode,
    input  logic                             sd_clock_in,
    input  logic [1:0]                       sd_data_in,
    input  logic                             output_clock,
    input  logic                             sync,
    output logic [1:0][OUTPUT_SIZE-1:0]      sample_data,
    output logic [1:0]                       sample_valid,
    output sd_sample_pkg::channel_id_t [1:0] sample_dest,
    output logic [1:0]                       code_error
);

    for (genvar ch = 0; ch < 2; ch++) begin : gen_channel
        sd_channel #(
            .PROCESSING_RESOLUTION (PROCESSING_RESOLUTION),
            .RESULT_RESOLUTION     (RESULT_RESOLUTION),
            .OUTPUT_SIZE           (OUTPUT_SIZE),
            .OUTPUT_SHIFT          (OUTPUT_SHIFT),
            .CHANNEL_ID            (sd_sample_pkg::channel_id_t'(ch))
        ) u_sd_channel (
            .clock        (clock),
            .rst_n        (rst_n),
            .line_mode    (line_mode),
            .sd_clock_in  (sd_clock_in),
            .sd_data_in   (sd_data_in[ch]),
            .output_clock (output_clock),
            .sync         (sync),
            .sample_data  (sample_data[ch]),
            .sample_valid (sample_valid[ch]),
            .sample_dest  (sample_dest[ch]),
            .code_error   (code_error[ch])
        );
    end

endmodule

//--- logic/sd_channel.sv
// One ADC channel, decoder to signed sample; a sample not taken on sync is simply lost
// Counts of 2**RESULT_RESOLUTION or more after the shift clamp to the largest positive result
`timescale 1ns/1ps

module sd_channel #(
    parameter int                        PROCESSING_RESOLUTION = 24,
    parameter int                        RESULT_RESOLUTION     = 8,
    parameter int                        OUTPUT_SIZE           = 16,
    parameter int                        OUTPUT_SHIFT          = 1,
    parameter sd_sample_pkg::channel_id_t CHANNEL_ID            = '0
) (
    input  logic                       clock,
    input  logic                       rst_n,
    input  sd_line_pkg::line_mode_e    line_mode,
    input  logic                       sd_clock_in,
    input  logic                       sd_data_in,
    input  logic                       output_clock,
    input  logic                       sync,
    output logic [OUTPUT_SIZE-1:0]     sample_data,
    output logic                       sample_valid,
    output sd_sample_pkg::channel_id_t sample_dest,
    output logic                       code_error
);

    localparam logic [RESULT_RESOLUTION-1:0] half_range = {1'b1, {(RESULT_RESOLUTION-1){1'b0}}};
    localparam logic [RESULT_RESOLUTION-1:0] max_result = {1'b0, {(RESULT_RESOLUTION-1){1'b1}}};

    logic                             bit_data;
    logic                             bit_strobe;
    logic [PROCESSING_RESOLUTION-1:0] integral;
    logic [PROCESSING_RESOLUTION-1:0] window_count;
    logic                             window_done;
    logic [PROCESSING_RESOLUTION-1:0] shifted_full;
    logic [RESULT_RESOLUTION:0]       shifted_count;
    logic [RESULT_RESOLUTION-1:0]     result;

    sd_manchester_decoder u_decoder (
        .clock       (clock),
        .rst_n       (rst_n),
        .line_mode   (line_mode),
        .sd_clock_in (sd_clock_in),
        .sd_data_in  (sd_data_in),
        .bit_data    (bit_data),
        .bit_strobe  (bit_strobe),
        .code_error  (code_error)
    );

    sd_integrator #(
        .PROCESSING_RESOLUTION (PROCESSING_RESOLUTION)
    ) u_integrator (
        .clock      (clock),
        .rst_n      (rst_n),
        .bit_data   (bit_data),
        .bit_strobe (bit_strobe),
        .integral   (integral)
    );

    sd_differentiator #(
        .PROCESSING_RESOLUTION (PROCESSING_RESOLUTION)
    ) u_differentiator (
        .clock        (clock),
        .rst_n        (rst_n),
        .output_clock (output_clock),
        .integral     (integral),
        .window_count (window_count),
        .window_done  (window_done)
    );

    assign shifted_full = window_count >> OUTPUT_SHIFT;

    // Bit RESULT_RESOLUTION of the shifted count marks an overrange window
    always_comb begin
        if (shifted_count[RESULT_RESOLUTION]) begin
            result = max_result;
        end else begin
            result = shifted_count[RESULT_RESOLUTION-1:0] - half_range;
        end
    end

    // The count starts at zero so an early sync reports the most negative value
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            shifted_count <= '0;
            sample_valid  <= 1'b0;
        end else begin
            sample_valid <= sync;
            if (window_done) begin
                shifted_count <= shifted_full[RESULT_RESOLUTION:0];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (sync) begin
            sample_data <= {{(OUTPUT_SIZE-RESULT_RESOLUTION){result[RESULT_RESOLUTION-1]}}, result};
            sample_dest <= CHANNEL_ID;
        end
    end

    // sync is a single-cycle request, so each request gives exactly one sample
    assert property (@(posedge clock) disable iff (!rst_n) sample_valid |=> !sample_valid);

endmodule

//--- logic/sd_differentiator.sv
// Second CIC stage, output_clock must be synchronous to clock
// window_count is the number of ones seen between two output_clock rises
`timescale 1ns/1ps

module sd_differentiator #(
    parameter int PROCESSING_RESOLUTION = 24
) (
    input  logic                             clock,
    input  logic                             rst_n,
    input  logic                             output_clock,
    input  logic [PROCESSING_RESOLUTION-1:0] integral,
    output logic [PROCESSING_RESOLUTION-1:0] window_count,
    output logic                             window_done
);

    logic                             output_clock_prev;
    logic                             window_rise;
    logic [PROCESSING_RESOLUTION-1:0] captured;

    assign window_rise = output_clock & ~output_clock_prev;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            output_clock_prev <= 1'b0;
            captured          <= '0;
            window_count      <= '0;
            window_done       <= 1'b0;
        end else begin
            output_clock_prev <= output_clock;
            window_done       <= window_rise;
            if (window_rise) begin
                // Modulo subtraction undoes any wrap of the integrator
                window_count <= integral - captured;
                captured     <= integral;
            end
        end
    end

    // The output stage registers exactly once per window
    assert property (@(posedge clock) disable iff (!rst_n) window_done |=> !window_done);

endmodule

//--- logic/sd_integrator.sv
// First CIC stage, counts ones and wraps freely at the processing width
`timescale 1ns/1ps

module sd_integrator #(
    parameter int PROCESSING_RESOLUTION = 24
) (
    input  logic                             clock,
    input  logic                             rst_n,
    input  logic                             bit_data,
    input  logic                             bit_strobe,
    output logic [PROCESSING_RESOLUTION-1:0] integral
);

    logic [PROCESSING_RESOLUTION-1:0] bit_value;

    // Zero-extend the decoded bit to the accumulator width
    assign bit_value = {{(PROCESSING_RESOLUTION-1){1'b0}}, bit_data};

    // Overflow is harmless, the differentiator subtracts modulo the same width
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            integral <= '0;
        end else if (bit_strobe) begin
            integral <= integral + bit_value;
        end
    end

endmodule

//--- logic/sd_manchester_decoder.sv
// sd_clock_in and sd_data_in must be synchronous to clock, edges are found against last cycle
// code_error is sticky and only reset clears it
`timescale 1ns/1ps

module sd_manchester_decoder (
    input  logic                    clock,
    input  logic                    rst_n,
    input  sd_line_pkg::line_mode_e line_mode,
    input  logic                    sd_clock_in,
    input  logic                    sd_data_in,
    output logic                    bit_data,
    output logic                    bit_strobe,
    output logic                    code_error
);

    sd_line_pkg::dec_state_e state;
    logic sd_clock_prev;
    logic first_half;
    logic clock_rise;
    logic clock_fall;
    logic take_plain;
    logic take_manchester;

    assign clock_rise = sd_clock_in & ~sd_clock_prev;
    assign clock_fall = ~sd_clock_in & sd_clock_prev;

    // A plain bit is complete on the rising edge, a Manchester bit on the falling edge
    assign take_plain = (line_mode == sd_line_pkg::line_plain) && clock_rise;
    assign take_manchester = (line_mode == sd_line_pkg::line_manchester)
                             && (state == sd_line_pkg::dec_first_half) && clock_fall;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state         <= sd_line_pkg::dec_idle;
            sd_clock_prev <= 1'b0;
            bit_strobe    <= 1'b0;
            code_error    <= 1'b0;
        end else begin
            sd_clock_prev <= sd_clock_in;
            bit_strobe    <= take_plain | take_manchester;
            // Both halves equal means the line is not a valid Manchester symbol
            if (take_manchester && (sd_data_in == first_half)) begin
                code_error <= 1'b1;
            end
            if (line_mode == sd_line_pkg::line_plain) begin
                state <= sd_line_pkg::dec_idle;
            end else if (clock_rise) begin
                state <= sd_line_pkg::dec_first_half;
            end else if (take_manchester) begin
                state <= sd_line_pkg::dec_second_half;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (clock_rise) begin
            first_half <= sd_data_in;
        end
        if (take_plain) begin
            bit_data <= sd_data_in;
        end else if (take_manchester) begin
            bit_data <= first_half;
        end
    end

    // One strobe per sd_clock_in period, so never two in a row
    assert property (@(posedge clock) disable iff (!rst_n) bit_strobe |=> !bit_strobe);

    // Once plain mode has been held, the Manchester second half is never entered
    assert property (@(posedge clock) disable iff (!rst_n)
        (line_mode == sd_line_pkg::line_plain) [*2] |-> (state != sd_line_pkg::dec_second_half));

endmodule

//--- logic/sd_sample_pkg.sv
// Sample-side types and the default widths that the top level hands down
// Defaults assume a first-order CIC and 512-bit decimation windows

package sd_sample_pkg;

    // Destination number carried with every output sample
    typedef logic [1:0] channel_id_t;

    // Width of the integrator and differentiator
    localparam int default_processing_resolution = 24;

    // Width of the signed result before sign extension
    localparam int default_result_resolution = 8;

    // Width of sample_data
    localparam int default_output_size = 16;

    // Right shift applied to the window count
    localparam int default_output_shift = 1;

endpackage

//--- logic/sd_line_pkg.sv
// Line-side encodings shared by the decoder and everything that selects its mode
// Manchester puts the bit in the high half of sd_clock_in and its inverse in the low half

package sd_line_pkg;

    // How the modulator bit stream is coded on the wire
    typedef enum logic {
        line_plain      = 1'b0,
        line_manchester = 1'b1
    } line_mode_e;

    // Progress through one Manchester bit
    typedef enum logic [1:0] {
        dec_idle        = 2'd0,
        dec_first_half  = 2'd1,
        dec_second_half = 2'd2
    } dec_state_e;

endpackage
